// ==== hw/pad_pkg.sv ====
// ============================
// pad ring widths, lane sizes and synchronizer depth
// io bus word and lane enable types
// ============================
`default_nettype none

package pad_pkg;

	// io bus
	localparam int IO_AD_W = 16;		// multiplexed address/data bus
	localparam int IO_LANE_W = 8;		// bits per output enable lane
	localparam int IO_LANES = 2;		// byte lanes on the io bus
	localparam int IO_CS_W = 4;			// pio chip selects

	// nand flash
	localparam int FL_CE_W = 4;			// flash chip enables

	// general purpose and joy channel pins
	localparam int GPIO_W = 4;			// gpio pins
	localparam int JCHAN_W = 3;			// open drain joy channels

	// two flops per asynchronous pin input
	localparam int SYNC_STAGES = 2;

	typedef logic [IO_AD_W-1:0] io_data_t;	// io bus word
	typedef logic [IO_LANES-1:0] io_oe_t;	// one enable per byte lane

endpackage

`default_nettype wire

// ==== hw/sync_2ff.sv ====
// ============================
// multi-bit synchronizer for asynchronous pin inputs
// ============================
`default_nettype none
`timescale 1ns/100ps

module sync_2ff #(
	parameter int width = 1					// bits synchronized side by side
) (
	input wire logic sysclk,
	input wire logic reset_l,				// sync reset, active high
	input wire logic [width-1:0] async_in,	// raw pin values
	output logic [width-1:0] sync_out		// pin values in sysclk domain
);
	import pad_pkg::*;

	logic [width-1:0] sync_q [SYNC_STAGES];	// flop chain, stage 0 samples the pin

	always_ff @(posedge sysclk)
	begin
		if (reset_l)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;				// clear every stage
		end
		else
		begin
			sync_q[0] <= async_in;				// may go metastable here
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];		// settle one more cycle
		end
	end

	// last stage is the only one the core sees
	assign sync_out = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== hw/io_bus_pads.sv ====
// ============================
// io bus data, strobe and chip select pad registers
// dma request and interrupt synchronizers
// ============================
`default_nettype none
`timescale 1ns/100ps

module io_bus_pads (
	input wire logic sysclk,
	input wire logic reset_l,						// sync reset, active high
	input wire pad_pkg::io_data_t io_out,			// core output data
	input wire pad_pkg::io_oe_t io_oe,				// core lane enables
	input wire logic io_ena,						// input capture enable
	input wire logic io_ale,						// address latch enable
	input wire logic [pad_pkg::IO_CS_W-1:0] io_cs,	// pio chip selects
	input wire logic io_ior,						// read pulse
	input wire logic io_iow,						// write pulse
	input wire logic io_rst,						// io bus reset
	input wire logic io_dmack,						// dma acknowledge
	input wire pad_pkg::io_data_t pad_io_ad_in,		// data pins, input side
	input wire logic pad_io_dmarq,					// dma request pin
	input wire logic pad_io_intr,					// device interrupt pin
	output pad_pkg::io_data_t io_in,				// captured input data
	output logic io_dmarq,							// synchronized dma request
	output logic io_intr,							// synchronized interrupt
	output pad_pkg::io_data_t pad_io_ad_out,		// data pins, output side
	output pad_pkg::io_data_t pad_io_ad_oe,			// data pins, per bit enable
	output logic pad_io_ale,						// ale pin
	output logic [pad_pkg::IO_CS_W-1:0] pad_io_cs,	// cs pins, active low
	output logic pad_io_ior,						// ior pin, active low
	output logic pad_io_iow,						// iow pin, active low
	output logic pad_io_rst,						// rst pin, active low
	output logic pad_io_dmack						// dmack pin, active low
);
	import pad_pkg::*;

	io_oe_t rio_oe;					// registered lane enables
	logic [1:0] irq_sync;			// dmarq and intr after the synchronizer

	// output registers, strobes inverted for the pins
	always_ff @(posedge sysclk)
	begin
		if (reset_l)
		begin
			pad_io_ad_out <= '0;
			rio_oe <= '0;				// bus floats in reset
			pad_io_ale <= 1'b0;
			pad_io_cs <= '1;			// all selects inactive
			pad_io_ior <= 1'b1;
			pad_io_iow <= 1'b1;
			pad_io_rst <= 1'b1;
			pad_io_dmack <= 1'b1;
		end
		else
		begin
			pad_io_ad_out <= io_out;
			rio_oe <= io_oe;
			pad_io_ale <= io_ale;		// ale is active high on the pin
			pad_io_cs <= ~io_cs;
			pad_io_ior <= ~io_ior;
			pad_io_iow <= ~io_iow;
			pad_io_rst <= ~io_rst;
			pad_io_dmack <= ~io_dmack;
		end
	end

	// each lane enable covers its own byte of the bus
	always_comb
	begin
		for (int l = 0; l < IO_LANES; l++)
			pad_io_ad_oe[l*IO_LANE_W +: IO_LANE_W] = {IO_LANE_W{rio_oe[l]}};
	end

	// input register with clock enable
	always_ff @(posedge sysclk)
	begin
		if (reset_l)
			io_in <= '0;
		else if (io_ena)
			io_in <= pad_io_ad_in;		// hold when not enabled
	end

	sync_2ff #(
		.width(2)
	) u_irq_sync (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.async_in({pad_io_dmarq, pad_io_intr}),
		.sync_out(irq_sync)
	);

	assign io_dmarq = irq_sync[1];
	assign io_intr = irq_sync[0];

	// read and write strobes never overlap on the pins
	assert property (@(posedge sysclk) disable iff (reset_l)
		!(!pad_io_ior && !pad_io_iow))
		else $error("io bus ior and iow pins low in the same cycle");

endmodule

`default_nettype wire

// ==== hw/flash_pads.sv ====
// ============================
// nand flash control output registers
// ready/busy and module detect synchronizers
// ============================
`default_nettype none
`timescale 1ns/100ps

module flash_pads (
	input wire logic sysclk,
	input wire logic reset_l,						// sync reset, active high
	input wire logic [pad_pkg::FL_CE_W-1:0] fl_ce,	// chip enables
	input wire logic fl_cle,						// command latch enable
	input wire logic fl_ale,						// address latch enable
	input wire logic fl_we,							// write enable
	input wire logic fl_re,							// read enable
	input wire logic fl_wp,							// write protect
	input wire logic pad_fl_ryby,					// ready/busy pin
	input wire logic pad_fl_md,						// module detect pin
	output logic [pad_pkg::FL_CE_W-1:0] pad_fl_ce,	// ce pins, active low
	output logic pad_fl_cle,						// cle pin
	output logic pad_fl_ale,						// ale pin
	output logic pad_fl_we,							// we pin, active low
	output logic pad_fl_re,							// re pin, active low
	output logic pad_fl_wp,							// wp pin, active low
	output logic fl_ryby,							// synchronized ready/busy
	output logic fl_md								// synchronized module detect
);
	import pad_pkg::*;

	logic [1:0] stat_sync;			// ryby and md in sysclk domain

	always_ff @(posedge sysclk)
	begin
		if (reset_l)
		begin
			pad_fl_ce <= {FL_CE_W{1'b1}};	// no chip selected
			pad_fl_cle <= 1'b0;
			pad_fl_ale <= 1'b0;
			pad_fl_we <= 1'b1;
			pad_fl_re <= 1'b1;
			pad_fl_wp <= 1'b1;				// inactive level on the pin
		end
		else
		begin
			pad_fl_ce <= ~fl_ce;
			pad_fl_cle <= fl_cle;			// latch enables stay high active
			pad_fl_ale <= fl_ale;
			pad_fl_we <= ~fl_we;
			pad_fl_re <= ~fl_re;
			pad_fl_wp <= ~fl_wp;
		end
	end

	sync_2ff #(
		.width(2)
	) u_stat_sync (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.async_in({pad_fl_ryby, pad_fl_md}),
		.sync_out(stat_sync)
	);

	assign fl_ryby = stat_sync[1];
	assign fl_md = stat_sync[0];

	// flash never sees read and write strobes together
	assert property (@(posedge sysclk) disable iff (reset_l)
		!(!pad_fl_we && !pad_fl_re))
		else $error("flash we and re pins low in the same cycle");

endmodule

`default_nettype wire

// ==== hw/port_pads.sv ====
// ============================
// gpio pad registers and input synchronizer
// open drain joy channel pads
// ============================
`default_nettype none
`timescale 1ns/100ps

module port_pads (
	input wire logic sysclk,
	input wire logic reset_l,							// sync reset, active high
	input wire logic [pad_pkg::GPIO_W-1:0] gpio_oe,		// gpio output enables
	input wire logic [pad_pkg::GPIO_W-1:0] gpio_out,	// gpio output values
	input wire logic [pad_pkg::GPIO_W-1:0] pad_gpio_in,	// input side of gpio pins
	input wire logic [pad_pkg::JCHAN_W-1:0] jchan_ena,	// per bit capture enable
	input wire logic [pad_pkg::JCHAN_W-1:0] jchan_oe,	// pull jchan low
	input wire logic [pad_pkg::JCHAN_W-1:0] pad_jchan_in,	// input side of jchan pins
	output logic [pad_pkg::GPIO_W-1:0] pad_gpio_out,	// output side of gpio pins
	output logic [pad_pkg::GPIO_W-1:0] pad_gpio_oe,		// gpio pin enables
	output logic [pad_pkg::GPIO_W-1:0] gpio_in,			// synchronized gpio
	output logic [pad_pkg::JCHAN_W-1:0] pad_jchan_oe,	// open drain enables
	output logic [pad_pkg::JCHAN_W-1:0] jchan_in		// captured jchan values
);
	import pad_pkg::*;

	always_ff @(posedge sysclk)
	begin
		if (reset_l)
		begin
			pad_gpio_oe <= '0;			// all gpio float
			pad_gpio_out <= '0;
		end
		else
		begin
			pad_gpio_oe <= gpio_oe;
			pad_gpio_out <= gpio_out;
		end
	end

	sync_2ff #(
		.width(GPIO_W)
	) u_gpio_sync (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.async_in(pad_gpio_in),
		.sync_out(gpio_in)
	);

	// pin only ever drives 0, so the enable is the whole output
	assign pad_jchan_oe = jchan_oe;

	always_ff @(posedge sysclk)
	begin
		if (reset_l)
			jchan_in <= '0;
		else
		begin
			for (int i = 0; i < JCHAN_W; i++)
				if (jchan_ena[i])
					jchan_in[i] <= pad_jchan_in[i];	// each bit has its own enable
		end
	end

endmodule

`default_nettype wire

// ==== hw/pad_ring.sv ====
// ============================
// pad ring top, io bus, flash and port pad groups
// ============================
`default_nettype none
`timescale 1ns/100ps

module pad_ring (
	input wire logic sysclk,
	input wire logic reset_l,							// sync reset, active high
	// io bus core side
	input wire pad_pkg::io_data_t io_out,
	input wire pad_pkg::io_oe_t io_oe,
	input wire logic io_ena,
	input wire logic io_ale,
	input wire logic [pad_pkg::IO_CS_W-1:0] io_cs,
	input wire logic io_ior,
	input wire logic io_iow,
	input wire logic io_rst,
	input wire logic io_dmack,
	output wire pad_pkg::io_data_t io_in,
	output wire logic io_dmarq,
	output wire logic io_intr,
	// io bus pins
	input wire pad_pkg::io_data_t pad_io_ad_in,
	input wire logic pad_io_dmarq,
	input wire logic pad_io_intr,
	output wire pad_pkg::io_data_t pad_io_ad_out,
	output wire pad_pkg::io_data_t pad_io_ad_oe,
	output wire logic pad_io_ale,
	output wire logic [pad_pkg::IO_CS_W-1:0] pad_io_cs,
	output wire logic pad_io_ior,
	output wire logic pad_io_iow,
	output wire logic pad_io_rst,
	output wire logic pad_io_dmack,
	// flash core side
	input wire logic [pad_pkg::FL_CE_W-1:0] fl_ce,
	input wire logic fl_cle,
	input wire logic fl_ale,
	input wire logic fl_we,
	input wire logic fl_re,
	input wire logic fl_wp,
	output wire logic fl_ryby,
	output wire logic fl_md,
	// flash pins
	input wire logic pad_fl_ryby,
	input wire logic pad_fl_md,
	output wire logic [pad_pkg::FL_CE_W-1:0] pad_fl_ce,
	output wire logic pad_fl_cle,
	output wire logic pad_fl_ale,
	output wire logic pad_fl_we,
	output wire logic pad_fl_re,
	output wire logic pad_fl_wp,
	// gpio and joy channel
	input wire logic [pad_pkg::GPIO_W-1:0] gpio_oe,
	input wire logic [pad_pkg::GPIO_W-1:0] gpio_out,
	input wire logic [pad_pkg::GPIO_W-1:0] pad_gpio_in,
	input wire logic [pad_pkg::JCHAN_W-1:0] jchan_ena,
	input wire logic [pad_pkg::JCHAN_W-1:0] jchan_oe,
	input wire logic [pad_pkg::JCHAN_W-1:0] pad_jchan_in,
	output wire logic [pad_pkg::GPIO_W-1:0] pad_gpio_out,
	output wire logic [pad_pkg::GPIO_W-1:0] pad_gpio_oe,
	output wire logic [pad_pkg::GPIO_W-1:0] gpio_in,
	output wire logic [pad_pkg::JCHAN_W-1:0] pad_jchan_oe,
	output wire logic [pad_pkg::JCHAN_W-1:0] jchan_in
);
	import pad_pkg::*;

	io_bus_pads u_io_bus_pads (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.io_out(io_out),
		.io_oe(io_oe),
		.io_ena(io_ena),
		.io_ale(io_ale),
		.io_cs(io_cs),
		.io_ior(io_ior),
		.io_iow(io_iow),
		.io_rst(io_rst),
		.io_dmack(io_dmack),
		.pad_io_ad_in(pad_io_ad_in),
		.pad_io_dmarq(pad_io_dmarq),
		.pad_io_intr(pad_io_intr),
		.io_in(io_in),
		.io_dmarq(io_dmarq),
		.io_intr(io_intr),
		.pad_io_ad_out(pad_io_ad_out),
		.pad_io_ad_oe(pad_io_ad_oe),
		.pad_io_ale(pad_io_ale),
		.pad_io_cs(pad_io_cs),
		.pad_io_ior(pad_io_ior),
		.pad_io_iow(pad_io_iow),
		.pad_io_rst(pad_io_rst),
		.pad_io_dmack(pad_io_dmack)
	);

	flash_pads u_flash_pads (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.fl_ce(fl_ce),
		.fl_cle(fl_cle),
		.fl_ale(fl_ale),
		.fl_we(fl_we),
		.fl_re(fl_re),
		.fl_wp(fl_wp),
		.pad_fl_ryby(pad_fl_ryby),
		.pad_fl_md(pad_fl_md),
		.pad_fl_ce(pad_fl_ce),
		.pad_fl_cle(pad_fl_cle),
		.pad_fl_ale(pad_fl_ale),
		.pad_fl_we(pad_fl_we),
		.pad_fl_re(pad_fl_re),
		.pad_fl_wp(pad_fl_wp),
		.fl_ryby(fl_ryby),
		.fl_md(fl_md)
	);

	port_pads u_port_pads (
		.sysclk(sysclk),
		.reset_l(reset_l),
		.gpio_oe(gpio_oe),
		.gpio_out(gpio_out),
		.pad_gpio_in(pad_gpio_in),
		.jchan_ena(jchan_ena),
		.jchan_oe(jchan_oe),
		.pad_jchan_in(pad_jchan_in),
		.pad_gpio_out(pad_gpio_out),
		.pad_gpio_oe(pad_gpio_oe),
		.gpio_in(gpio_in),
		.pad_jchan_oe(pad_jchan_oe),
		.jchan_in(jchan_in)
	);

endmodule

`default_nettype wire

// ==== dv/pad_checker.sv ====
// ============================
// reference model of the pad ring pins
// per cycle comparison and error lines
// ============================
`default_nettype none
`timescale 1ns/100ps

module pad_checker (
	input wire logic sysclk,
	input wire logic reset_l,							// sync reset, active high
	input wire logic signed [31:0] row_idx,				// row on the inputs, -1 in reset
	input wire pad_pkg::io_data_t io_out, pad_io_ad_in, io_in, pad_io_ad_out, pad_io_ad_oe,
	input wire pad_pkg::io_oe_t io_oe,
	input wire logic io_ena, io_ale, io_ior, io_iow, io_rst, io_dmack,
	input wire logic pad_io_dmarq, pad_io_intr, io_dmarq, io_intr,
	input wire logic pad_io_ale, pad_io_ior, pad_io_iow, pad_io_rst, pad_io_dmack,
	input wire logic [pad_pkg::IO_CS_W-1:0] io_cs, pad_io_cs,
	input wire logic [pad_pkg::FL_CE_W-1:0] fl_ce, pad_fl_ce,
	input wire logic fl_cle, fl_ale, fl_we, fl_re, fl_wp, pad_fl_ryby, pad_fl_md,
	input wire logic fl_ryby, fl_md, pad_fl_cle, pad_fl_ale, pad_fl_we, pad_fl_re, pad_fl_wp,
	input wire logic [pad_pkg::GPIO_W-1:0] gpio_oe, gpio_out, pad_gpio_in,
	input wire logic [pad_pkg::GPIO_W-1:0] pad_gpio_out, pad_gpio_oe, gpio_in,
	input wire logic [pad_pkg::JCHAN_W-1:0] jchan_ena, jchan_oe, pad_jchan_in,
	input wire logic [pad_pkg::JCHAN_W-1:0] pad_jchan_oe, jchan_in,
	output int n_pass,									// cycles with every output right
	output int n_fail									// cycles with a mismatch
);
	import pad_pkg::*;

	io_data_t x_ad_out, x_ad_oe, x_io_in;		// expected io bus pins and capture
	logic [IO_CS_W-1:0] x_io_cs;
	logic x_io_ale, x_ior, x_iow, x_io_rst, x_dmack;
	logic [FL_CE_W-1:0] x_fl_ce;
	logic x_cle, x_fl_ale, x_we, x_re, x_wp;
	logic [GPIO_W-1:0] x_gpio_oe, x_gpio_out;
	logic [JCHAN_W-1:0] x_jchan_in;
	logic [GPIO_W+3:0] pins_d1, pins_d2;		// dmarq, intr, ryby, md, gpio pins
	logic armed;								// set once reset has reached the dut
	int row_d1;									// row whose inputs the outputs show
	int cyc_errs;

	initial
	begin
		armed = 1'b0;
		row_d1 = -1;
		n_pass = 0;
		n_fail = 0;
	end

	task automatic compare_sig(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("error: time %0t %s expected %0h actual %0h", $time, name, exp, act);
			cyc_errs++;
		end
	endtask

	always @(posedge sysclk)
	begin
		if (armed)
		begin
			cyc_errs = 0;
			compare_sig("pad_io_ad_out", 32'(x_ad_out), 32'(pad_io_ad_out));
			compare_sig("pad_io_ad_oe", 32'(x_ad_oe), 32'(pad_io_ad_oe));
			compare_sig("pad_io_ale", 32'(x_io_ale), 32'(pad_io_ale));
			compare_sig("pad_io_cs", 32'(x_io_cs), 32'(pad_io_cs));
			compare_sig("pad_io_ior", 32'(x_ior), 32'(pad_io_ior));
			compare_sig("pad_io_iow", 32'(x_iow), 32'(pad_io_iow));
			compare_sig("pad_io_rst", 32'(x_io_rst), 32'(pad_io_rst));
			compare_sig("pad_io_dmack", 32'(x_dmack), 32'(pad_io_dmack));
			compare_sig("io_in", 32'(x_io_in), 32'(io_in));
			compare_sig("io_dmarq", 32'(pins_d2[GPIO_W+3]), 32'(io_dmarq));
			compare_sig("io_intr", 32'(pins_d2[GPIO_W+2]), 32'(io_intr));
			compare_sig("pad_fl_ce", 32'(x_fl_ce), 32'(pad_fl_ce));
			compare_sig("pad_fl_cle", 32'(x_cle), 32'(pad_fl_cle));
			compare_sig("pad_fl_ale", 32'(x_fl_ale), 32'(pad_fl_ale));
			compare_sig("pad_fl_we", 32'(x_we), 32'(pad_fl_we));
			compare_sig("pad_fl_re", 32'(x_re), 32'(pad_fl_re));
			compare_sig("pad_fl_wp", 32'(x_wp), 32'(pad_fl_wp));
			compare_sig("fl_ryby", 32'(pins_d2[GPIO_W+1]), 32'(fl_ryby));
			compare_sig("fl_md", 32'(pins_d2[GPIO_W]), 32'(fl_md));
			compare_sig("pad_gpio_oe", 32'(x_gpio_oe), 32'(pad_gpio_oe));
			compare_sig("pad_gpio_out", 32'(x_gpio_out), 32'(pad_gpio_out));
			compare_sig("gpio_in", 32'(pins_d2[GPIO_W-1:0]), 32'(gpio_in));
			compare_sig("pad_jchan_oe", 32'(jchan_oe), 32'(pad_jchan_oe));	// no latency
			compare_sig("jchan_in", 32'(x_jchan_in), 32'(jchan_in));
			if (cyc_errs == 0)
				n_pass++;
			else
				n_fail++;
			$display("check %0d, inputs of %s: %s", n_pass + n_fail,
				row_d1 < 0 ? "reset" : $sformatf("row %0d", row_d1),
				cyc_errs == 0 ? "pass" : "mismatch");
		end
		armed <= armed | reset_l;
		row_d1 <= reset_l ? -1 : row_idx;
		// two flop pin synchronizers, cleared as a whole by reset
		pins_d1 <= reset_l ? '0 : {pad_io_dmarq, pad_io_intr, pad_fl_ryby, pad_fl_md, pad_gpio_in};
		pins_d2 <= reset_l ? '0 : pins_d1;
		if (reset_l)
		begin
			x_ad_out <= '0;
			x_ad_oe <= '0;					// pins float in reset
			x_io_in <= '0;
			x_io_cs <= '1;					// active low strobes idle high
			{x_io_ale, x_ior, x_iow, x_io_rst, x_dmack} <= 5'b01111;
			x_fl_ce <= '1;
			{x_cle, x_fl_ale, x_we, x_re, x_wp} <= 5'b00111;
			x_gpio_oe <= '0;
			x_gpio_out <= '0;
			x_jchan_in <= '0;
		end
		else
		begin
			x_ad_out <= io_out;
			x_ad_oe <= {{IO_LANE_W{io_oe[1]}}, {IO_LANE_W{io_oe[0]}}};	// byte lanes
			x_io_in <= io_ena ? pad_io_ad_in : x_io_in;
			x_io_cs <= ~io_cs;
			{x_io_ale, x_ior, x_iow, x_io_rst, x_dmack} <= {io_ale, ~io_ior, ~io_iow,
				~io_rst, ~io_dmack};
			x_fl_ce <= ~fl_ce;
			{x_cle, x_fl_ale, x_we, x_re, x_wp} <= {fl_cle, fl_ale, ~fl_we, ~fl_re, ~fl_wp};
			x_gpio_oe <= gpio_oe;
			x_gpio_out <= gpio_out;
			x_jchan_in <= (jchan_ena & pad_jchan_in) | (~jchan_ena & x_jchan_in);	// per bit
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_pad_ring.sv ====
// ============================
// pad ring testbench, clock, reset, stimulus table and timeout
// ============================
`default_nettype none
`timescale 1ns/100ps

module tb_pad_ring;
	import pad_pkg::*;

	localparam int RESET_CYC = 10;
	localparam int NROWS = 24;
	localparam int CYC_LIMIT = RESET_CYC + NROWS + 10;	// cycles before the run is cut off
	localparam int RAND_SEED = 89;

	// one table row in the order of apply_row
	typedef struct packed {
		io_data_t io_out;
		io_oe_t io_oe;
		logic io_ena, io_ale;
		logic [IO_CS_W-1:0] io_cs;
		logic io_ior, io_iow, io_rst, io_dmack;
		io_data_t pad_io_ad_in;
		logic pad_io_dmarq, pad_io_intr;
		logic [FL_CE_W-1:0] fl_ce;
		logic fl_cle, fl_ale, fl_we, fl_re, fl_wp;
		logic pad_fl_ryby, pad_fl_md;
		logic [GPIO_W-1:0] gpio_oe, gpio_out, pad_gpio_in;
		logic [JCHAN_W-1:0] jchan_ena, jchan_oe, pad_jchan_in;
	} stim_t;

	logic sysclk, reset_l;
	io_data_t io_out, pad_io_ad_in, io_in, pad_io_ad_out, pad_io_ad_oe;
	io_oe_t io_oe;
	logic io_ena, io_ale, io_ior, io_iow, io_rst, io_dmack, pad_io_dmarq, pad_io_intr;
	logic [IO_CS_W-1:0] io_cs, pad_io_cs;
	logic io_dmarq, io_intr, pad_io_ale, pad_io_ior, pad_io_iow, pad_io_rst, pad_io_dmack;
	logic [FL_CE_W-1:0] fl_ce, pad_fl_ce;
	logic fl_cle, fl_ale, fl_we, fl_re, fl_wp, pad_fl_ryby, pad_fl_md;
	logic fl_ryby, fl_md, pad_fl_cle, pad_fl_ale, pad_fl_we, pad_fl_re, pad_fl_wp;
	logic [GPIO_W-1:0] gpio_oe, gpio_out, pad_gpio_in, pad_gpio_out, pad_gpio_oe, gpio_in;
	logic [JCHAN_W-1:0] jchan_ena, jchan_oe, pad_jchan_in, pad_jchan_oe, jchan_in;
	int row_idx;					// -1 while in reset
	int n_pass, n_fail;
	int cyc_cnt;
	stim_t table_q [NROWS];

	pad_ring UUT (.*);
	pad_checker u_checker (.*);

	task automatic apply_row(input stim_t s);
		{io_out, io_oe, io_ena, io_ale, io_cs, io_ior, io_iow, io_rst, io_dmack,
			pad_io_ad_in, pad_io_dmarq, pad_io_intr,
			fl_ce, fl_cle, fl_ale, fl_we, fl_re, fl_wp, pad_fl_ryby, pad_fl_md,
			gpio_oe, gpio_out, pad_gpio_in, jchan_ena, jchan_oe, pad_jchan_in} = s;
	endtask

	task automatic build_table();
		stim_t s;
		logic [95:0] rnd;
		for (int r = 0; r < NROWS; r++)
		begin
			rnd = {$urandom(), $urandom(), $urandom()};
			s = rnd[$bits(stim_t)-1:0];			// random fill by default
			case (r)
				0: s = '0;							// everything idle
				1: s = '1;							// every line active
				2:
				begin
					s = '0;
					s.io_oe = 2'b01;				// low lane only
					s.io_ena = 1'b1;
					s.pad_io_ad_in = 16'hc3a1;
					s.io_out = 16'h5aa5;
				end
				3:
				begin
					s = '0;
					s.io_oe = 2'b10;				// high lane with capture held
					s.pad_io_ad_in = 16'hffff;
					s.jchan_ena = 3'b101;
					s.pad_jchan_in = 3'b111;
				end
				4:
				begin
					s = '0;
					s.pad_io_dmarq = 1'b1;			// one cycle pin pulses
					s.pad_fl_md = 1'b1;
					s.pad_gpio_in = 4'b0101;
					s.gpio_out = 4'b1010;			// driven value with oe off
					s.fl_ce = 4'b0001;
					s.fl_we = 1'b1;
				end
				5:
				begin
					s = '0;
					s.gpio_out = 4'b1010;
					s.io_ior = 1'b1;
					s.jchan_oe = '1;
					s.fl_re = 1'b1;
					s.fl_wp = 1'b1;
					s.pad_fl_ryby = 1'b1;
					s.pad_io_intr = 1'b1;
				end
				default: ;
			endcase
			// read and write strobes are never raised together
			if (s.io_ior && s.io_iow)
				s.io_iow = 1'b0;
			if (s.fl_we && s.fl_re)
				s.fl_re = 1'b0;
			table_q[r] = s;
		end
	endtask

	initial
	begin
		sysclk = 1'b0;
		forever #4 sysclk = ~sysclk;		// 8 ns period
	end

	initial
	begin
		void'($urandom(RAND_SEED));
		reset_l = 1'b1;						// reset held from time 0
		row_idx = -1;
		apply_row('0);
		build_table();
		repeat (RESET_CYC) @(negedge sysclk);
		reset_l = 1'b0;
		for (int r = 0; r < NROWS; r++)
		begin
			row_idx = r;
			apply_row(table_q[r]);			// inputs change on the falling edge
			@(negedge sysclk);
		end
		repeat (SYNC_STAGES + 1) @(negedge sysclk);	// last row through the synchronizers
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		cyc_cnt = 0;
		while (cyc_cnt < CYC_LIMIT)
		begin
			@(posedge sysclk);
			cyc_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/pad_pkg.sv
hw/sync_2ff.sv
hw/io_bus_pads.sv
hw/flash_pads.sv
hw/port_pads.sv
hw/pad_ring.sv
dv/pad_checker.sv
dv/tb_pad_ring.sv

// ==== Makefile ====
# Verilator build and run of the pad ring testbench

VERILATOR ?= verilator
TOP ?= tb_pad_ring
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hw/*.sv dv/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
